// ==== logic/prefix_fe_pkg.sv ====
// Prefix feature extractor definitions
package prefix_fe_pkg;

  // Width of one stream character.
  localparam int CHAR_W = 8;

  // Each pattern group is a chain of this many comparator slices, a to d.
  localparam int SLICES = 4;

  // One configuration word per slice.
  localparam int CFG_W = 12;

  // Field positions inside the slice configuration word, from low to high.
  localparam int CFG_MATCH_LSB    = 0;   // match_val occupies bits 7:0.
  localparam int CFG_TYPE_LSB     = 8;   // cmp_type occupies bits 9:8.
  localparam int CFG_NODELAY_BIT  = 10;  // Chain on the same character.
  localparam int CFG_USEPRIOR_BIT = 11;  // Require a hit from the slice before.

  // Compare operation of one slice.
  // The encoding is fixed because software writes it straight into the config word.
  typedef enum logic [1:0] {
    CMP_EQ   = 2'd0,  // Character equals match_val.
    CMP_NE   = 2'd1,  // Character differs from match_val.
    CMP_GE   = 2'd2,  // Character is at least match_val.
    CMP_PASS = 2'd3   // Always true, used to pad short patterns.
  } cmp_type_e;

endpackage

// ==== logic/prefix_fe_cmp.sv ====
// Comparator slice
module prefix_fe_cmp #(
  parameter bit IS_FIRST = 1'b0  // Set on slice a, which has no slice before it.
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [prefix_fe_pkg::CHAR_W-1:0] char_in,            // Current character.
  input  logic                             char_valid,         // One strobe per character.
  input  logic                             prior_in,           // Prior hit on the last character.
  input  logic                             prior_in_no_delay,  // Prior hit on this character.
  input  logic                             use_prior,
  input  logic                             no_delay,
  input  logic [prefix_fe_pkg::CHAR_W-1:0] match_val,
  input  prefix_fe_pkg::cmp_type_e         cmp_type,
  output logic                             hit_now,    // Combinational hit on char_in.
  output logic                             prior_out   // Hit on the last accepted character.
);

  import prefix_fe_pkg::*;

  logic cmp_hit;   // Raw compare result before any chaining.
  logic prior_ok;  // Qualifier from the slice before. It is 1 when not chaining.

  // The compare itself. Only the low two bits of the word are decoded.
  always_comb begin
    case (cmp_type)
      CMP_EQ:  cmp_hit = (char_in == match_val);
      CMP_NE:  cmp_hit = (char_in != match_val);
      CMP_GE:  cmp_hit = (char_in >= match_val);  // Unsigned byte compare.
      default: cmp_hit = 1'b1;                    // CMP_PASS.
    endcase
  end

  // Slice a has nothing in front of it.
  // Its chaining controls and prior inputs play no part in the hit.
  if (IS_FIRST) begin : g_first
    assign prior_ok = 1'b1;
  end else begin : g_chained
    // With no_delay the previous slice must hit on this same byte.
    // Otherwise it must have hit on the byte before, which builds a sequence.
    assign prior_ok = !use_prior || (no_delay ? prior_in_no_delay : prior_in);
  end

  assign hit_now = cmp_hit & prior_ok;

  // The registered hit only moves on an accepted character and holds in between.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prior_out <= 1'b0;
    end else if (char_valid) begin
      prior_out <= hit_now;  // Visible in the cycle after the character.
    end
  end

endmodule

// ==== logic/prefix_fe_cmpx4.sv ====
// Four slice pattern group
module prefix_fe_cmpx4 (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [prefix_fe_pkg::CHAR_W-1:0] char_in,
  input  logic                             char_valid,
  // Slice a. Its chaining controls are ignored by the slice.
  input  logic                             use_prior_a,
  input  logic                             no_delay_a,
  input  logic [prefix_fe_pkg::CHAR_W-1:0] match_val_a,
  input  prefix_fe_pkg::cmp_type_e         cmp_type_a,
  // Slice b.
  input  logic                             use_prior_b,
  input  logic                             no_delay_b,
  input  logic [prefix_fe_pkg::CHAR_W-1:0] match_val_b,
  input  prefix_fe_pkg::cmp_type_e         cmp_type_b,
  // Slice c.
  input  logic                             use_prior_c,
  input  logic                             no_delay_c,
  input  logic [prefix_fe_pkg::CHAR_W-1:0] match_val_c,
  input  prefix_fe_pkg::cmp_type_e         cmp_type_c,
  // Slice d.
  input  logic                             use_prior_d,
  input  logic                             no_delay_d,
  input  logic [prefix_fe_pkg::CHAR_W-1:0] match_val_d,
  input  prefix_fe_pkg::cmp_type_e         cmp_type_d,
  output logic                             feature_hit  // Registered hit of slice d.
);

  // Registered and combinational hits of the first three slices feed the next one.
  logic prior_out_a, prior_out_b, prior_out_c;
  logic hit_now_a, hit_now_b, hit_now_c;

  // Slice a starts the chain. Its prior inputs are tied off.
  prefix_fe_cmp #(.IS_FIRST(1'b1)) prefix_fe_cmp_a (
    .clk               (clk),
    .rst_n             (rst_n),
    .char_in           (char_in),
    .char_valid        (char_valid),
    .prior_in          (1'b0),
    .prior_in_no_delay (1'b0),
    .use_prior         (use_prior_a),
    .no_delay          (no_delay_a),
    .match_val         (match_val_a),
    .cmp_type          (cmp_type_a),
    .hit_now           (hit_now_a),
    .prior_out         (prior_out_a)
  );

  prefix_fe_cmp #(.IS_FIRST(1'b0)) prefix_fe_cmp_b (
    .clk               (clk),
    .rst_n             (rst_n),
    .char_in           (char_in),
    .char_valid        (char_valid),
    .prior_in          (prior_out_a),  // Slice a on the previous character.
    .prior_in_no_delay (hit_now_a),    // Slice a on this character.
    .use_prior         (use_prior_b),
    .no_delay          (no_delay_b),
    .match_val         (match_val_b),
    .cmp_type          (cmp_type_b),
    .hit_now           (hit_now_b),
    .prior_out         (prior_out_b)
  );

  prefix_fe_cmp #(.IS_FIRST(1'b0)) prefix_fe_cmp_c (
    .clk               (clk),
    .rst_n             (rst_n),
    .char_in           (char_in),
    .char_valid        (char_valid),
    .prior_in          (prior_out_b),
    .prior_in_no_delay (hit_now_b),
    .use_prior         (use_prior_c),
    .no_delay          (no_delay_c),
    .match_val         (match_val_c),
    .cmp_type          (cmp_type_c),
    .hit_now           (hit_now_c),
    .prior_out         (prior_out_c)
  );

  // Slice d closes the chain. Its combinational hit has no consumer.
  // With no_delay set all the way down, the same-character path crosses all four slices.
  prefix_fe_cmp #(.IS_FIRST(1'b0)) prefix_fe_cmp_d (
    .clk               (clk),
    .rst_n             (rst_n),
    .char_in           (char_in),
    .char_valid        (char_valid),
    .prior_in          (prior_out_c),
    .prior_in_no_delay (hit_now_c),
    .use_prior         (use_prior_d),
    .no_delay          (no_delay_d),
    .match_val         (match_val_d),
    .cmp_type          (cmp_type_d),
    .hit_now           (),
    .prior_out         (feature_hit)  // The group's feature hit.
  );

endmodule

// ==== logic/prefix_fe_cfg.sv ====
// Slice configuration registers
module prefix_fe_cfg #(
  parameter  int NUM_GROUPS = 4,  // Number of pattern groups.
  localparam int ADDR_W     = $clog2(NUM_GROUPS * prefix_fe_pkg::SLICES)
) (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                                         cfg_wr,     // One-cycle write strobe.
  input  logic [ADDR_W-1:0]                            cfg_addr,   // Group * 4 + slice.
  input  logic [prefix_fe_pkg::CFG_W-1:0]              cfg_wdata,
  output logic [NUM_GROUPS*prefix_fe_pkg::SLICES-1:0]  use_prior,
  output logic [NUM_GROUPS*prefix_fe_pkg::SLICES-1:0]  no_delay,
  output logic [NUM_GROUPS*prefix_fe_pkg::SLICES*prefix_fe_pkg::CHAR_W-1:0] match_val,
  output logic [NUM_GROUPS*prefix_fe_pkg::SLICES*2-1:0] cmp_type
);

  import prefix_fe_pkg::*;

  localparam int NUM_SLOTS = NUM_GROUPS * SLICES;  // One word per slice.
  localparam int TYPE_W    = $bits(cmp_type_e);

  logic [CFG_W-1:0] cfg_mem [NUM_SLOTS];  // Slice a of group g sits at index g*4.
  logic             addr_ok;              // Address lands on an existing slice.

  assign addr_ok = (int'(cfg_addr) < NUM_SLOTS);

  // Writes land at the edge that ends the strobe cycle.
  // They take effect from the next cycle.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // A word of zero is equal-to-0x00 with no chaining.
      for (int i = 0; i < NUM_SLOTS; i++) begin
        cfg_mem[i] <= '0;
      end
    end else if (cfg_wr && addr_ok) begin
      cfg_mem[cfg_addr] <= cfg_wdata;  // Stray addresses are dropped.
    end
  end

  // Fan the fields of each word out to its slice.
  for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
    assign use_prior[i] = cfg_mem[i][CFG_USEPRIOR_BIT];
    assign no_delay[i]  = cfg_mem[i][CFG_NODELAY_BIT];
    assign match_val[i*CHAR_W +: CHAR_W] = cfg_mem[i][CFG_MATCH_LSB +: CHAR_W];
    assign cmp_type[i*TYPE_W +: TYPE_W]  = cfg_mem[i][CFG_TYPE_LSB +: TYPE_W];
  end

endmodule

// ==== logic/prefix_fe_accum.sv ====
// Per-frame feature accumulator
module prefix_fe_accum #(
  parameter int NUM_GROUPS = 4,  // Number of pattern groups.
  parameter int CNT_W      = 8   // Width of each saturating hit counter.
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        char_valid,
  input  logic                        char_last,      // Qualified by char_valid.
  input  logic [NUM_GROUPS-1:0]       feature_hit,    // Registered group hits.
  output logic [NUM_GROUPS-1:0]       feature_vec,    // Groups that hit at least once.
  output logic [NUM_GROUPS*CNT_W-1:0] feature_cnt,    // Hit count per group.
  output logic                        feature_valid   // One-cycle report strobe.
);

  localparam logic [CNT_W-1:0] CNT_MAX = '1;  // Counters stick here.

  logic                  valid_r;  // A character was accepted last cycle.
  logic                  last_r;   // That character closed the frame.
  logic [NUM_GROUPS-1:0] seen_q;   // Sticky hit flags of the open frame.
  logic [NUM_GROUPS-1:0] seen_d;
  logic [CNT_W-1:0]      cnt_q [NUM_GROUPS];
  logic [CNT_W-1:0]      cnt_d [NUM_GROUPS];

  // The group hits reflect the character from one cycle back.
  // Folding on valid_r counts each accepted character exactly once.
  always_comb begin
    for (int g = 0; g < NUM_GROUPS; g++) begin
      seen_d[g] = seen_q[g] | (valid_r & feature_hit[g]);
      if (valid_r && feature_hit[g] && (cnt_q[g] != CNT_MAX)) begin
        cnt_d[g] = cnt_q[g] + 1'b1;
      end else begin
        cnt_d[g] = cnt_q[g];  // No hit, or already saturated.
      end
    end
  end

  // Control state and running totals.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_r       <= 1'b0;
      last_r        <= 1'b0;
      feature_valid <= 1'b0;
      seen_q        <= '0;
      for (int g = 0; g < NUM_GROUPS; g++) begin
        cnt_q[g] <= '0;
      end
    end else begin
      valid_r       <= char_valid;
      last_r        <= char_valid & char_last;
      feature_valid <= last_r;  // Two cycles after the last character.
      // Frame end empties the totals, so a character in this cycle starts from zero.
      seen_q <= last_r ? '0 : seen_d;
      for (int g = 0; g < NUM_GROUPS; g++) begin
        cnt_q[g] <= last_r ? '0 : cnt_d[g];
      end
    end
  end

  // The report holds until the next frame ends.
  always_ff @(posedge clk) begin
    if (last_r) begin
      feature_vec <= seen_d;  // Includes the hit on the last character.
      for (int g = 0; g < NUM_GROUPS; g++) begin
        feature_cnt[g*CNT_W +: CNT_W] <= cnt_d[g];
      end
    end
  end

endmodule

// ==== logic/prefix_fe_top.sv ====
// Prefix feature extractor top level
module prefix_fe_top #(
  parameter  int NUM_GROUPS = 4,  // Pattern groups in parallel.
  parameter  int CNT_W      = 8,  // Hit counter width.
  localparam int ADDR_W     = $clog2(NUM_GROUPS * prefix_fe_pkg::SLICES)
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [prefix_fe_pkg::CHAR_W-1:0] char_in,
  input  logic                             char_valid,
  input  logic                             char_last,
  input  logic                             cfg_wr,
  input  logic [ADDR_W-1:0]                cfg_addr,
  input  logic [prefix_fe_pkg::CFG_W-1:0]  cfg_wdata,
  output logic [NUM_GROUPS-1:0]            feature_vec,
  output logic [NUM_GROUPS*CNT_W-1:0]      feature_cnt,
  output logic                             feature_valid
);

  import prefix_fe_pkg::*;

  localparam int NUM_SLOTS = NUM_GROUPS * SLICES;
  localparam int TYPE_W    = $bits(cmp_type_e);

  // Flat per-slice fields. Slice s of group g sits at index g*4+s.
  logic [NUM_SLOTS-1:0]        use_prior;
  logic [NUM_SLOTS-1:0]        no_delay;
  logic [NUM_SLOTS*CHAR_W-1:0] match_val;
  logic [NUM_SLOTS*TYPE_W-1:0] cmp_type;
  logic [NUM_GROUPS-1:0]       feature_hit;  // One registered hit per group.

  prefix_fe_cfg #(.NUM_GROUPS(NUM_GROUPS)) prefix_fe_cfg_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .use_prior (use_prior),
    .no_delay  (no_delay),
    .match_val (match_val),
    .cmp_type  (cmp_type)
  );

  // One chain of four slices per group. All groups see the same character.
  for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_group
    localparam int B = g * SLICES;  // Index of slice a.
    prefix_fe_cmpx4 prefix_fe_cmpx4_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .char_in     (char_in),
      .char_valid  (char_valid),
      .use_prior_a (use_prior[B]),
      .no_delay_a  (no_delay[B]),
      .match_val_a (match_val[B*CHAR_W +: CHAR_W]),
      .cmp_type_a  (cmp_type_e'(cmp_type[B*TYPE_W +: TYPE_W])),
      .use_prior_b (use_prior[B+1]),
      .no_delay_b  (no_delay[B+1]),
      .match_val_b (match_val[(B+1)*CHAR_W +: CHAR_W]),
      .cmp_type_b  (cmp_type_e'(cmp_type[(B+1)*TYPE_W +: TYPE_W])),
      .use_prior_c (use_prior[B+2]),
      .no_delay_c  (no_delay[B+2]),
      .match_val_c (match_val[(B+2)*CHAR_W +: CHAR_W]),
      .cmp_type_c  (cmp_type_e'(cmp_type[(B+2)*TYPE_W +: TYPE_W])),
      .use_prior_d (use_prior[B+3]),
      .no_delay_d  (no_delay[B+3]),
      .match_val_d (match_val[(B+3)*CHAR_W +: CHAR_W]),
      .cmp_type_d  (cmp_type_e'(cmp_type[(B+3)*TYPE_W +: TYPE_W])),
      .feature_hit (feature_hit[g])
    );
  end

  // Latency from the last character to feature_valid is two cycles.
  prefix_fe_accum #(.NUM_GROUPS(NUM_GROUPS), .CNT_W(CNT_W)) prefix_fe_accum_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .char_valid    (char_valid),
    .char_last     (char_last),
    .feature_hit   (feature_hit),
    .feature_vec   (feature_vec),
    .feature_cnt   (feature_cnt),
    .feature_valid (feature_valid)
  );

endmodule

// ==== bench/prefix_fe_checker.sv ====
// Top level timing assertions
module prefix_fe_checker (
  input logic clk,
  input logic rst_n,
  input logic char_valid,
  input logic char_last,
  input logic feature_valid
);

  // A reset cycle leaves the report strobe low.
  a_reset_clear: assert property (@(posedge clk) !rst_n |=> !feature_valid)
    else $error("feature_valid high right after a reset cycle");

  // The report is a single-cycle pulse.
  a_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    feature_valid |=> !feature_valid)
    else $error("feature_valid held high for two cycles");

  // Every frame end produces a report two cycles later.
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    (char_valid && char_last) |-> ##2 feature_valid)
    else $error("No feature_valid two cycles after the last character");

  // And no report appears without a frame end.
  a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
    feature_valid |-> $past(char_valid && char_last, 2))
    else $error("feature_valid without a frame end two cycles before");

endmodule

// ==== bench/prefix_fe_tb.sv ====
// Prefix feature extractor testbench
module prefix_fe_tb;

  import prefix_fe_pkg::*;

  localparam int NUM_GROUPS = 4;
  localparam int CNT_W      = 8;
  localparam int CNT_MAX    = (1 << CNT_W) - 1;  // Counters saturate here.
  localparam int TIMEOUT    = 20;                // Cycles allowed for a report to show up.
  localparam logic [11:0] PASS_ND = {1'b1, 1'b1, CMP_PASS, 8'h00};  // Forwards the slice before.

  logic                        clk = 1'b0;
  logic                        rst_n;
  logic [7:0]                  char_in;
  logic                        char_valid;
  logic                        char_last;
  logic                        cfg_wr;
  logic [3:0]                  cfg_addr;
  logic [11:0]                 cfg_wdata;
  logic [NUM_GROUPS-1:0]       feature_vec;
  logic [NUM_GROUPS*CNT_W-1:0] feature_cnt;
  logic                        feature_valid;

  logic [11:0]           cfg_mirror [NUM_GROUPS*4];  // Copy of every written config word.
  logic [3:0]            m_prior [NUM_GROUPS];       // Model of each slice's registered hit.
  logic [NUM_GROUPS-1:0] m_seen;                     // Expected sticky flags of the open frame.
  int                    m_cnt [NUM_GROUPS];         // Expected counts of the open frame.
  logic [7:0]            frame_q [$];                // Characters of the next frame.
  int                    err_cnt;
  int                    err_mark;
  int                    test_cnt;
  int                    fail_cnt;
  int                    frame_cnt;
  bit                    timed_out;

  always #10 clk = ~clk;  // Period of 20.

  prefix_fe_top #(.NUM_GROUPS(NUM_GROUPS), .CNT_W(CNT_W)) prefix_fe_top_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .char_in       (char_in),
    .char_valid    (char_valid),
    .char_last     (char_last),
    .cfg_wr        (cfg_wr),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .feature_vec   (feature_vec),
    .feature_cnt   (feature_cnt),
    .feature_valid (feature_valid)
  );

  bind prefix_fe_top prefix_fe_checker prefix_fe_checker_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .char_valid    (char_valid),
    .char_last     (char_last),
    .feature_valid (feature_valid)
  );

  // Compare rule of one slice. Types 0 to 3 are equal, not equal, at least and always.
  function automatic logic cmp_model(input logic [7:0] c, input logic [7:0] m,
                                     input logic [1:0] t);
    case (t)
      2'd0:    return c == m;
      2'd1:    return c != m;
      2'd2:    return c >= m;
      default: return 1'b1;
    endcase
  endfunction

  // Pushes one accepted character through every modelled chain and into the totals.
  function automatic void model_char(input logic [7:0] c);
    logic [11:0] w;
    logic [3:0]  now;
    logic        ok;
    logic        pn;  // Hit of the slice before on this character.
    logic        pr;  // Hit of the slice before on the previous character.
    for (int g = 0; g < NUM_GROUPS; g++) begin
      pn = 1'b0;
      pr = 1'b0;
      for (int s = 0; s < 4; s++) begin
        w = cfg_mirror[g*4+s];
        ok = (s == 0 || !w[11]) ? 1'b1 : (w[10] ? pn : pr);  // Slice a never chains.
        now[s] = cmp_model(c, w[7:0], w[9:8]) & ok;
        pn = now[s];
        pr = m_prior[g][s];
      end
      m_prior[g] = now;
      m_seen[g] = m_seen[g] | now[3];
      if (now[3] && m_cnt[g] < CNT_MAX) begin
        m_cnt[g]++;
      end
    end
  endfunction

  function automatic logic [11:0] cfg_word(input logic up, input logic nd,
                                           input logic [1:0] t, input logic [7:0] m);
    return {up, nd, t, m};  // use_prior, no_delay, type, match value.
  endfunction

  task automatic write_slice(input int g, input int s, input logic [11:0] w);
    cfg_wr = 1'b1;
    cfg_addr = 4'(g*4 + s);
    cfg_wdata = w;
    cfg_mirror[g*4+s] = w;
    @(posedge clk);
    #2;
    cfg_wr = 1'b0;
  endtask

  task automatic set_group(input int g, input logic [11:0] wa, input logic [11:0] wb,
                           input logic [11:0] wc, input logic [11:0] wd);
    write_slice(g, 0, wa);
    write_slice(g, 1, wb);
    write_slice(g, 2, wc);
    write_slice(g, 3, wd);
  endtask

  task automatic push_str(input string s);
    for (int i = 0; i < s.len(); i++) begin
      frame_q.push_back(s[i]);
    end
  endtask

  // Sends the queued frame, waits for the report and compares it with the model.
  task automatic run_frame(input bit gaps);
    int n;
    int wait_cyc;
    if (timed_out) begin
      frame_q.delete();  // The run is already lost.
      return;
    end
    n = frame_q.size();
    frame_cnt++;
    for (int i = 0; i < n; i++) begin
      if (gaps && $urandom_range(3) == 0) begin
        char_valid = 1'b0;  // The chains must hold over this idle cycle.
        @(posedge clk);
        #2;
      end
      char_in = frame_q[i];
      char_valid = 1'b1;
      char_last = (i == n - 1);
      model_char(frame_q[i]);
      @(posedge clk);
      #2;
    end
    char_valid = 1'b0;
    char_last = 1'b0;
    wait_cyc = 0;
    while (!feature_valid && wait_cyc < TIMEOUT) begin
      @(posedge clk);
      #2;
      wait_cyc++;
    end
    if (!feature_valid) begin
      $display("Timeout: no report within %0d cycles after frame %0d", TIMEOUT, frame_cnt);
      timed_out = 1'b1;
    end else begin
      if (wait_cyc != 1) begin
        $display("ERROR at %0t: frame %0d report latency %0d, expected 2",
                 $time, frame_cnt, wait_cyc + 1);
        err_cnt++;
      end
      for (int g = 0; g < NUM_GROUPS; g++) begin
        if (feature_vec[g] !== m_seen[g]) begin
          $display("ERROR at %0t: frame %0d group %0d flag %b, expected %b",
                   $time, frame_cnt, g, feature_vec[g], m_seen[g]);
          err_cnt++;
        end
        if (feature_cnt[g*CNT_W +: CNT_W] !== CNT_W'(m_cnt[g])) begin
          $display("ERROR at %0t: frame %0d group %0d count %0d, expected %0d",
                   $time, frame_cnt, g, feature_cnt[g*CNT_W +: CNT_W], m_cnt[g]);
          err_cnt++;
        end
      end
    end
    frame_q.delete();
    m_seen = '0;  // The DUT clears its totals at the frame end too.
    for (int g = 0; g < NUM_GROUPS; g++) begin
      m_cnt[g] = 0;
    end
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt != err_mark || timed_out) begin
      fail_cnt++;
      $display("%s: FAIL, %0d errors", name, err_cnt - err_mark);
    end else begin
      $display("%s: ok", name);
    end
    err_mark = err_cnt;
  endtask

  task automatic test_reset_defaults();
    push_str("xyz1");  // Default words match 0x00 only.
    run_frame(1'b0);
    frame_q = '{8'h41, 8'h00, 8'h00, 8'h42, 8'h00};
    run_frame(1'b0);
    end_test("reset_defaults");
  endtask

  task automatic test_single_compares();
    set_group(0, cfg_word(1'b0, 1'b0, CMP_EQ, "e"), PASS_ND, PASS_ND, PASS_ND);
    set_group(1, cfg_word(1'b0, 1'b0, CMP_NE, "e"), PASS_ND, PASS_ND, PASS_ND);
    set_group(2, cfg_word(1'b0, 1'b0, CMP_GE, "m"), PASS_ND, PASS_ND, PASS_ND);
    set_group(3, cfg_word(1'b0, 1'b0, CMP_PASS, 8'h00), PASS_ND, PASS_ND, PASS_ND);
    push_str(".hello, mellow world");
    run_frame(1'b0);
    push_str(".zzz~ EEEe");
    run_frame(1'b0);
    end_test("single_compares");
  endtask

  task automatic test_sequence();
    set_group(0, cfg_word(1'b0, 1'b0, CMP_EQ, "c"), cfg_word(1'b1, 1'b0, CMP_EQ, "a"),
              cfg_word(1'b1, 1'b0, CMP_EQ, "f"), cfg_word(1'b1, 1'b0, CMP_EQ, "e"));
    push_str(".xcafex");  // Once.
    run_frame(1'b0);
    push_str(".cafe.cafe");  // Twice.
    run_frame(1'b0);
    push_str(".caf.");  // Partial.
    run_frame(1'b0);
    push_str(".abcd");  // Absent.
    run_frame(1'b0);
    end_test("sequence");
  endtask

  task automatic test_same_char();
    // Letters from 'a' upward except 'q'.
    set_group(1, cfg_word(1'b0, 1'b0, CMP_GE, "a"), cfg_word(1'b1, 1'b1, CMP_NE, "q"),
              PASS_ND, PASS_ND);
    // Slice b has no_delay but no use_prior, so slice a is ignored.
    set_group(2, cfg_word(1'b0, 1'b0, CMP_EQ, "o"), cfg_word(1'b0, 1'b1, CMP_EQ, "x"),
              PASS_ND, PASS_ND);
    push_str(".quick brown fox jumps, quiz");
    run_frame(1'b0);
    end_test("same_char");
  endtask

  task automatic test_saturation();
    set_group(3, cfg_word(1'b0, 1'b0, CMP_EQ, "z"), PASS_ND, PASS_ND, PASS_ND);
    frame_q.push_back(".");
    repeat (CNT_MAX + 45) frame_q.push_back("z");
    run_frame(1'b0);
    push_str(".zz.");  // Must start again from zero.
    run_frame(1'b0);
    end_test("saturation");
  endtask

  task automatic test_random();
    int n;
    for (int f = 0; f < 24; f++) begin
      if (f % 4 == 0) begin
        for (int i = 0; i < NUM_GROUPS * 4; i++) begin
          write_slice(i / 4, i % 4, {1'($urandom_range(1)), 1'($urandom_range(1)),
                                     2'($urandom_range(3)), 8'("a" + $urandom_range(3))});
        end
      end
      frame_q.push_back(".");  // Separator.
      n = 1 + $urandom_range(11);
      repeat (n) frame_q.push_back(8'("a" + $urandom_range(3)));
      run_frame(1'b1);
    end
    end_test("random");
  endtask

  initial begin
    void'($urandom(77));
    rst_n = 1'b0;
    char_in = 8'h00;
    char_valid = 1'b0;
    char_last = 1'b0;
    cfg_wr = 1'b0;
    cfg_addr = 4'h0;
    cfg_wdata = 12'h000;
    err_cnt = 0;
    err_mark = 0;
    test_cnt = 0;
    fail_cnt = 0;
    frame_cnt = 0;
    timed_out = 1'b0;
    m_seen = '0;
    for (int i = 0; i < NUM_GROUPS * 4; i++) begin
      cfg_mirror[i] = 12'h000;
    end
    for (int g = 0; g < NUM_GROUPS; g++) begin
      m_prior[g] = 4'h0;
      m_cnt[g] = 0;
    end
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_reset_defaults();
    test_single_compares();
    test_sequence();
    test_same_char();
    test_saturation();
    test_random();
    $display("Tests %0d, failed %0d, value errors %0d, frames %0d",
             test_cnt, fail_cnt, err_cnt, frame_cnt);
    if (fail_cnt == 0 && err_cnt == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== prefix_fe_top.f ====
logic/prefix_fe_pkg.sv
logic/prefix_fe_cmp.sv
logic/prefix_fe_cmpx4.sv
logic/prefix_fe_cfg.sv
logic/prefix_fe_accum.sv
logic/prefix_fe_top.sv
bench/prefix_fe_checker.sv
bench/prefix_fe_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the prefix feature extractor testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert --top-module prefix_fe_tb \
  -f prefix_fe_top.f --Mdir obj_dir -o prefix_fe_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/prefix_fe_sim 2>&1)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1
